// File: src/fc_pkg.sv
package fc_pkg;

    // array geometry
    localparam int FC_TILE    = 120;  // PE lanes, also the largest tile
    localparam int DATA_W     = 8;
    localparam int PSUM_W     = 24;
    localparam int WBUF_W     = FC_TILE * DATA_W;

    // buffer sizes
    localparam int IBUF_DEPTH = 512;
    localparam int WBUF_DEPTH = 1024;
    localparam int PTR_W      = 10;

    localparam int IN_NODE_W  = 9;
    localparam int OUT_NODE_W = 7;
    localparam int MAX_OUT    = 84;

    // per-layer base addresses
    localparam logic [PTR_W-1:0] FC_WBUF_OFFSET_1ST = 10'd0;
    localparam logic [PTR_W-1:0] FC_WBUF_OFFSET_2ND = 10'd480;
    localparam logic [PTR_W-1:0] FC_WBUF_OFFSET_3RD = 10'd564;
    localparam logic [PTR_W-1:0] FC_IBUF_OFFSET_1ST = 10'd0;
    localparam logic [PTR_W-1:0] FC_IBUF_OFFSET_2ND = 10'd0;
    localparam logic [PTR_W-1:0] FC_IBUF_OFFSET_3RD = 10'd0;

    // controller states
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_IF_LOAD = 2'd1;
    localparam logic [1:0] ST_FC_OP   = 2'd2;

endpackage

// File: src/ifmap_buffer.sv
`timescale 1ns/1ps

module ifmap_buffer
    import fc_pkg::*;
(
    input  logic              clk,

    input  logic              wr_en_i,
    input  logic [PTR_W-1:0]  wr_addr_i,
    input  logic [DATA_W-1:0] wr_data_i,

    input  logic              rd_en_i,
    input  logic [PTR_W-1:0]  rd_addr_i,
    output logic [DATA_W-1:0] rd_data_o
);

    logic [DATA_W-1:0] mem [IBUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i[$clog2(IBUF_DEPTH)-1:0]] <= wr_data_i;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i[$clog2(IBUF_DEPTH)-1:0]];
        end
    end

    assert property (@(posedge clk)
        wr_en_i |-> wr_addr_i < IBUF_DEPTH);

endmodule

// File: src/weight_buffer.sv
`timescale 1ns/1ps

module weight_buffer
    import fc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              wr_en_i,
    input  logic [PTR_W-1:0]  wr_addr_i,
    input  logic [WBUF_W-1:0] wr_data_i,

    input  logic              rd_en_i,
    input  logic [PTR_W-1:0]  rd_addr_i,
    input  logic              zero_n_i,
    output logic [WBUF_W-1:0] rd_data_o
);

    // one word = one weight per PE lane
    logic [WBUF_W-1:0] mem [WBUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else if (!zero_n_i) begin
            rd_data_o <= '0;  // flush rows outside the layer
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: src/fc_pe_array.sv
`timescale 1ns/1ps

module fc_pe_array
    import fc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     load_i,
    input  logic signed [DATA_W-1:0] ifmap_i,
    input  logic [WBUF_W-1:0]        weight_i,

    output logic signed [PSUM_W-1:0] psum_o
);

    logic [$clog2(FC_TILE)-1:0] lane_idx;
    logic signed [DATA_W-1:0]   x_q [FC_TILE];
    logic signed [PSUM_W-1:0]   psum_q [FC_TILE];

    // stationary inputs, filled from lane 0 upwards
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_idx <= '0;
            for (int k = 0; k < FC_TILE; k++) begin
                x_q[k] <= '0;  // unloaded lanes see zero weights anyway
            end
        end else if (load_i) begin
            x_q[lane_idx] <= ifmap_i;
            lane_idx      <= lane_idx + 1'b1;
        end else begin
            lane_idx <= '0;
        end
    end

    for (genvar k = 0; k < FC_TILE; k++) begin : g_lane
        logic signed [DATA_W-1:0] w_skew;
        logic signed [PSUM_W-1:0] psum_in;

        if (k == 0) begin : g_head
            assign w_skew  = weight_i[DATA_W-1:0];
            assign psum_in = '0;
        end else begin : g_tail
            logic [DATA_W-1:0] dly [k];  // k-cycle skew

            always_ff @(posedge clk) begin
                dly[0] <= weight_i[k*DATA_W +: DATA_W];
                for (int i = 1; i < k; i++) begin
                    dly[i] <= dly[i-1];
                end
            end

            assign w_skew  = dly[k-1];
            assign psum_in = psum_q[k-1];
        end

        always_ff @(posedge clk) begin
            psum_q[k] <= psum_in + x_q[k] * w_skew;
        end
    end

    assign psum_o = psum_q[FC_TILE-1];

endmodule

// File: src/fc_activation.sv
`timescale 1ns/1ps

module fc_activation
    import fc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     start_i,
    input  logic [IN_NODE_W-1:0]     in_node_num_i,
    input  logic [OUT_NODE_W-1:0]    out_node_num_i,

    input  logic                     valid_i,
    input  logic                     last_i,
    input  logic signed [PSUM_W-1:0] psum_i,

    output logic                     out_valid_o,
    output logic signed [PSUM_W-1:0] out_data_o,
    output logic                     out_last_o
);

    logic signed [PSUM_W-1:0] acc [MAX_OUT];
    logic [2:0]               tile_num, tile_idx;
    logic [OUT_NODE_W-1:0]    out_num, node_idx;
    logic [OUT_NODE_W-1:0]    emit_num, rd_idx;
    logic                     busy, emit, final_tile;

    assign final_tile = tile_idx == tile_num - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            tile_num    <= '0;
            tile_idx    <= '0;
            out_num     <= '0;
            node_idx    <= '0;
            emit        <= 1'b0;
            emit_num    <= '0;
            rd_idx      <= '0;
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
        end else begin
            out_valid_o <= emit;
            out_last_o  <= emit && (rd_idx == emit_num - 1'b1);

            if (start_i && !busy) begin
                busy     <= 1'b1;
                tile_num <= 3'((in_node_num_i + FC_TILE - 1) / FC_TILE);
                tile_idx <= '0;
                node_idx <= '0;
                out_num  <= out_node_num_i;
            end else if (valid_i) begin
                node_idx <= last_i ? '0 : node_idx + 1'b1;
                if (last_i) begin
                    tile_idx <= tile_idx + 1'b1;
                    if (final_tile) busy <= 1'b0;
                end
            end

            // result streaming, independent of the next layer's start
            if (emit) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == emit_num - 1'b1) emit <= 1'b0;
            end
            if (valid_i && last_i && final_tile) begin
                emit     <= 1'b1;
                emit_num <= out_num;
                rd_idx   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            acc[node_idx] <= (tile_idx == '0) ? psum_i : acc[node_idx] + psum_i;
        end
        out_data_o <= acc[rd_idx][PSUM_W-1] ? '0 : acc[rd_idx];  // relu
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        valid_i |-> node_idx < MAX_OUT);

endmodule

// File: src/fc_controller.sv
`timescale 1ns/1ps

module fc_controller
    import fc_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  start_i,
    input  logic [IN_NODE_W-1:0]  in_node_num_i,
    input  logic [OUT_NODE_W-1:0] out_node_num_i,
    input  logic [1:0]            nth_fully_i,

    output logic                  ifmap_rden_o,
    output logic [PTR_W-1:0]      ifmap_rdptr_o,
    output logic                  wbuf_rden_o,
    output logic [PTR_W-1:0]      wbuf_rdptr_o,
    output logic                  rst_buf_n_o,
    output logic                  pe_load_o,
    output logic                  valid_o,
    output logic                  last_o
);

    logic [1:0]            state, state_n;
    logic [IN_NODE_W-1:0]  cnt, cnt_n;
    logic [IN_NODE_W-1:0]  remain, remain_n;     // inputs not yet tiled
    logic [OUT_NODE_W-1:0] out_num, out_num_n;
    logic [PTR_W-1:0]      ibase, ibase_n;
    logic [PTR_W-1:0]      wbase, wbase_n;
    logic [PTR_W-1:0]      ioff, woff;
    logic [IN_NODE_W-1:0]  tile_len;
    logic                  more_tiles;

    logic                  ifmap_rden_n, wbuf_rden_n;
    logic [PTR_W-1:0]      ifmap_rdptr_n, wbuf_rdptr_n;
    logic                  rst_buf_n_n, valid_n, last_n;

    always_comb begin
        case (nth_fully_i)
            2'd0: begin
                ioff = FC_IBUF_OFFSET_1ST;
                woff = FC_WBUF_OFFSET_1ST;
            end
            2'd1: begin
                ioff = FC_IBUF_OFFSET_2ND;
                woff = FC_WBUF_OFFSET_2ND;
            end
            2'd2: begin
                ioff = FC_IBUF_OFFSET_3RD;
                woff = FC_WBUF_OFFSET_3RD;
            end
            default: begin
                ioff = '0;
                woff = '0;
            end
        endcase
    end

    assign more_tiles = remain > FC_TILE;
    assign tile_len   = more_tiles ? IN_NODE_W'(FC_TILE) : remain;

    always_comb begin
        state_n       = state;
        cnt_n         = cnt;
        remain_n      = remain;
        out_num_n     = out_num;
        ibase_n       = ibase;
        wbase_n       = wbase;
        ifmap_rden_n  = 1'b0;
        ifmap_rdptr_n = ifmap_rdptr_o;
        wbuf_rden_n   = 1'b0;
        wbuf_rdptr_n  = wbuf_rdptr_o;
        rst_buf_n_n   = 1'b1;
        valid_n       = 1'b0;
        last_n        = 1'b0;

        case (state)
            ST_IDLE: begin
                if (start_i) begin
                    state_n       = ST_IF_LOAD;
                    cnt_n         = '0;
                    remain_n      = in_node_num_i;
                    out_num_n     = out_node_num_i;
                    ibase_n       = ioff;
                    wbase_n       = woff;
                    ifmap_rden_n  = 1'b1;
                    ifmap_rdptr_n = ioff;
                end
            end
            ST_IF_LOAD: begin
                if (cnt == tile_len - 1'b1) begin
                    state_n      = ST_FC_OP;
                    cnt_n        = '0;
                    wbuf_rden_n  = 1'b1;  // first weight row of the tile
                    wbuf_rdptr_n = wbase;
                end else begin
                    cnt_n         = cnt + 1'b1;
                    ifmap_rden_n  = 1'b1;
                    ifmap_rdptr_n = ibase + PTR_W'(cnt_n);
                end
            end
            ST_FC_OP: begin
                if (last_o) begin
                    cnt_n = '0;
                    if (more_tiles) begin
                        state_n       = ST_IF_LOAD;
                        remain_n      = remain - IN_NODE_W'(FC_TILE);
                        ibase_n       = ibase + PTR_W'(FC_TILE);
                        wbase_n       = wbase + PTR_W'(FC_TILE);
                        ifmap_rden_n  = 1'b1;
                        ifmap_rdptr_n = ibase_n;
                    end else begin
                        state_n = ST_IDLE;
                    end
                end else begin
                    cnt_n        = cnt + 1'b1;
                    wbuf_rden_n  = 1'b1;
                    wbuf_rdptr_n = wbase + PTR_W'(cnt_n);
                    valid_n      = cnt >= FC_TILE;  // chain latency is 120 lanes
                    // rows past out_num are not part of this layer
                    rst_buf_n_n  = !(cnt >= out_num - 1'b1);
                    last_n       = cnt == FC_TILE - 1 + out_num;
                end
            end
            default: state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            cnt           <= '0;
            remain        <= '0;
            out_num       <= '0;
            ibase         <= '0;
            wbase         <= '0;
            ifmap_rden_o  <= 1'b0;
            ifmap_rdptr_o <= '0;
            wbuf_rden_o   <= 1'b0;
            wbuf_rdptr_o  <= '0;
            rst_buf_n_o   <= 1'b1;
            pe_load_o     <= 1'b0;
            valid_o       <= 1'b0;
            last_o        <= 1'b0;
        end else begin
            state         <= state_n;
            cnt           <= cnt_n;
            remain        <= remain_n;
            out_num       <= out_num_n;
            ibase         <= ibase_n;
            wbase         <= wbase_n;
            ifmap_rden_o  <= ifmap_rden_n;
            ifmap_rdptr_o <= ifmap_rdptr_n;
            wbuf_rden_o   <= wbuf_rden_n;
            wbuf_rdptr_o  <= wbuf_rdptr_n;
            rst_buf_n_o   <= rst_buf_n_n;
            pe_load_o     <= ifmap_rden_o;  // lines up with ifmap read data
            valid_o       <= valid_n;
            last_o        <= last_n;
        end
    end

    // buffers share no cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        !(ifmap_rden_o && wbuf_rden_o));

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(valid_o) |-> state == ST_FC_OP);

endmodule

// File: src/fc_top.sv
`timescale 1ns/1ps

module fc_top
    import fc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     start_i,
    input  logic [IN_NODE_W-1:0]     in_node_num_i,
    input  logic [OUT_NODE_W-1:0]    out_node_num_i,
    input  logic [1:0]               nth_fully_i,

    input  logic                     ifmap_wr_en_i,
    input  logic [PTR_W-1:0]         ifmap_wr_addr_i,
    input  logic [DATA_W-1:0]        ifmap_wr_data_i,
    input  logic                     wbuf_wr_en_i,
    input  logic [PTR_W-1:0]         wbuf_wr_addr_i,
    input  logic [WBUF_W-1:0]        wbuf_wr_data_i,

    output logic                     out_valid_o,
    output logic signed [PSUM_W-1:0] out_data_o,
    output logic                     out_last_o
);

    logic               ifmap_rden, wbuf_rden;
    logic [PTR_W-1:0]   ifmap_rdptr, wbuf_rdptr;
    logic               rst_buf_n, pe_load;
    logic               valid, last;
    logic [DATA_W-1:0]  ifmap_rdata;
    logic [WBUF_W-1:0]  wbuf_rdata;
    logic [PSUM_W-1:0]  psum;

    fc_controller u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .start_i(start_i), .in_node_num_i(in_node_num_i),
        .out_node_num_i(out_node_num_i), .nth_fully_i(nth_fully_i),
        .ifmap_rden_o(ifmap_rden), .ifmap_rdptr_o(ifmap_rdptr),
        .wbuf_rden_o(wbuf_rden), .wbuf_rdptr_o(wbuf_rdptr),
        .rst_buf_n_o(rst_buf_n), .pe_load_o(pe_load),
        .valid_o(valid), .last_o(last)
    );

    ifmap_buffer u_ibuf (
        .clk(clk),
        .wr_en_i(ifmap_wr_en_i), .wr_addr_i(ifmap_wr_addr_i), .wr_data_i(ifmap_wr_data_i),
        .rd_en_i(ifmap_rden), .rd_addr_i(ifmap_rdptr), .rd_data_o(ifmap_rdata)
    );

    weight_buffer u_wbuf (
        .clk(clk), .rst_n(rst_n),
        .wr_en_i(wbuf_wr_en_i), .wr_addr_i(wbuf_wr_addr_i), .wr_data_i(wbuf_wr_data_i),
        .rd_en_i(wbuf_rden), .rd_addr_i(wbuf_rdptr), .zero_n_i(rst_buf_n),
        .rd_data_o(wbuf_rdata)
    );

    fc_pe_array u_pe (
        .clk(clk), .rst_n(rst_n),
        .load_i(pe_load), .ifmap_i(ifmap_rdata), .weight_i(wbuf_rdata),
        .psum_o(psum)
    );

    fc_activation u_act (
        .clk(clk), .rst_n(rst_n),
        .start_i(start_i), .in_node_num_i(in_node_num_i), .out_node_num_i(out_node_num_i),
        .valid_i(valid), .last_i(last), .psum_i(psum),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_last_o(out_last_o)
    );

endmodule

// File: tests/tb_fc_top.sv
`timescale 1ns/1ps

module tb_fc_top
    import fc_pkg::*;
();

    localparam int NUM_TESTS = 5;
    localparam int MAX_WAIT  = 3000;  // cycles per wait loop

    // nth_fully, in_nodes, out_nodes
    int tbl [NUM_TESTS][3] = '{
        '{2, 84, 10},
        '{1, 120, 84},
        '{0, 400, 84},
        '{0, 130, 5},
        '{2, 1, 1}
    };

    logic                     clk;
    logic                     rst_n;
    logic                     start_i;
    logic [IN_NODE_W-1:0]     in_node_num_i;
    logic [OUT_NODE_W-1:0]    out_node_num_i;
    logic [1:0]               nth_fully_i;
    logic                     ifmap_wr_en_i;
    logic [PTR_W-1:0]         ifmap_wr_addr_i;
    logic [DATA_W-1:0]        ifmap_wr_data_i;
    logic                     wbuf_wr_en_i;
    logic [PTR_W-1:0]         wbuf_wr_addr_i;
    logic [WBUF_W-1:0]        wbuf_wr_data_i;
    logic                     out_valid_o;
    logic signed [PSUM_W-1:0] out_data_o;
    logic                     out_last_o;

    logic [31:0]              rng = 32'h3fc5_5363;
    logic signed [DATA_W-1:0] x_ref [IBUF_DEPTH];
    logic signed [DATA_W-1:0] w_ref [MAX_OUT][IBUF_DEPTH];  // output j, input i
    int                       expected [MAX_OUT];
    int                       errors = 0;
    int                       checks = 0;
    int                       neg_total = 0;

    fc_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic signed [DATA_W-1:0] small_value();  // -8..7
        logic [31:0] r;
        r = next_rand();
        return {{4{r[3]}}, r[3:0]};
    endfunction

    function automatic logic [DATA_W-1:0] junk_byte();
        logic [31:0] r;
        r = next_rand();
        return r[7:0] | 8'h01;  // never zero
    endfunction

    task automatic preload_buffers(input int nth, input int n_in, input int n_out);
        int                woff;
        int                ioff;
        int                ntiles;
        int                rel;
        int                t;
        int                j;
        int                i;
        logic [WBUF_W-1:0] word;
        case (nth)
            0: begin
                woff = int'(FC_WBUF_OFFSET_1ST);
                ioff = int'(FC_IBUF_OFFSET_1ST);
            end
            1: begin
                woff = int'(FC_WBUF_OFFSET_2ND);
                ioff = int'(FC_IBUF_OFFSET_2ND);
            end
            default: begin
                woff = int'(FC_WBUF_OFFSET_3RD);
                ioff = int'(FC_IBUF_OFFSET_3RD);
            end
        endcase
        ntiles = (n_in + FC_TILE - 1) / FC_TILE;
        for (j = 0; j < n_out; j++) begin
            for (i = 0; i < n_in; i++) begin
                w_ref[j][i] = small_value();
            end
        end
        for (int a = 0; a < IBUF_DEPTH; a++) begin
            @(negedge clk);
            ifmap_wr_en_i   = 1'b1;
            ifmap_wr_addr_i = PTR_W'(a);
            if (a >= ioff && a - ioff < n_in) begin
                x_ref[a - ioff] = small_value();
                ifmap_wr_data_i = x_ref[a - ioff];
            end else begin
                ifmap_wr_data_i = junk_byte();
            end
        end
        @(negedge clk);
        ifmap_wr_en_i = 1'b0;
        for (int a = 0; a < WBUF_DEPTH; a++) begin
            rel = a - woff;
            t   = rel / FC_TILE;
            j   = rel % FC_TILE;
            for (int k = 0; k < FC_TILE; k++) begin
                i = t * FC_TILE + k;
                if (rel >= 0 && t < ntiles && j < n_out) begin
                    word[k*DATA_W +: DATA_W] = (i < n_in) ? w_ref[j][i] : '0;  // padding lanes
                end else begin
                    word[k*DATA_W +: DATA_W] = junk_byte();
                end
            end
            @(negedge clk);
            wbuf_wr_en_i   = 1'b1;
            wbuf_wr_addr_i = PTR_W'(a);
            wbuf_wr_data_i = word;
        end
        @(negedge clk);
        wbuf_wr_en_i = 1'b0;
    endtask

    // relu of the full dot product per output node
    task automatic compute_expected(input int n_in, input int n_out, output int negs);
        int sum;
        negs = 0;
        for (int j = 0; j < n_out; j++) begin
            sum = 0;
            for (int i = 0; i < n_in; i++) begin
                sum += int'(x_ref[i]) * int'(w_ref[j][i]);
            end
            if (sum < 0) negs++;
            expected[j] = (sum < 0) ? 0 : sum;
        end
    endtask

    task automatic run_layer(input int idx, input int nth, input int n_in, input int n_out,
                             output bit hung);
        int beats;
        int cycles;
        int negs;
        int errors_before;
        bit done;
        errors_before = errors;
        beats  = 0;
        cycles = 0;
        done   = 1'b0;
        hung   = 1'b0;
        preload_buffers(nth, n_in, n_out);
        compute_expected(n_in, n_out, negs);
        neg_total += negs;
        @(negedge clk);
        nth_fully_i    = 2'(nth);
        in_node_num_i  = IN_NODE_W'(n_in);
        out_node_num_i = OUT_NODE_W'(n_out);
        start_i        = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        while (!done && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
            if (out_valid_o) begin
                checks++;
                assert (beats < n_out) else begin
                    $display("Error at %0t: test %0d extra out_valid_o beat %0d",
                             $time, idx, beats);
                    errors++;
                end
                if (beats < n_out) begin
                    checks += 2;
                    assert (int'(out_data_o) == expected[beats]) else begin
                        $display("Error at %0t: test %0d node %0d data %0d, expected %0d",
                                 $time, idx, beats, out_data_o, expected[beats]);
                        errors++;
                    end
                    assert (out_last_o == (beats == n_out - 1)) else begin
                        $display("Error at %0t: test %0d node %0d out_last_o is %0b",
                                 $time, idx, beats, out_last_o);
                        errors++;
                    end
                end
                beats++;
            end else begin
                checks++;
                assert (!out_last_o) else begin
                    $display("Error at %0t: test %0d out_last_o without out_valid_o", $time, idx);
                    errors++;
                end
            end
            if (out_last_o) done = 1'b1;
        end
        if (!done) begin
            $display("test %0d timed out: out_last_o did not arrive within %0d cycles, DUT hangs",
                     idx, MAX_WAIT);
            errors++;
            hung = 1'b1;
        end else begin
            checks++;
            assert (beats == n_out) else begin
                $display("Error at %0t: test %0d saw %0d beats, expected %0d",
                         $time, idx, beats, n_out);
                errors++;
            end
            repeat (5) begin  // nothing after the final node
                @(negedge clk);
                checks++;
                assert (!out_valid_o && !out_last_o) else begin
                    $display("Error at %0t: test %0d output strobe after out_last_o", $time, idx);
                    errors++;
                end
            end
        end
        $display("test %0d: layer %0d, %0d inputs, %0d outputs, %0d beats, %0d zeroed, %0s",
                 idx, nth, n_in, n_out, beats, negs,
                 (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        bit hung;
        int tests_run;
        hung            = 1'b0;
        tests_run       = 0;
        rst_n           = 1'b0;
        start_i         = 1'b0;
        in_node_num_i   = '0;
        out_node_num_i  = '0;
        nth_fully_i     = '0;
        ifmap_wr_en_i   = 1'b0;
        ifmap_wr_addr_i = '0;
        ifmap_wr_data_i = '0;
        wbuf_wr_en_i    = 1'b0;
        wbuf_wr_addr_i  = '0;
        wbuf_wr_data_i  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet outputs while idle
        repeat (8) begin
            @(negedge clk);
            checks++;
            assert (!out_valid_o && !out_last_o) else begin
                $display("Error at %0t: output strobe high before start_i", $time);
                errors++;
            end
        end

        for (int r = 0; r < NUM_TESTS && !hung; r++) begin
            run_layer(r, tbl[r][0], tbl[r][1], tbl[r][2], hung);
            tests_run++;
        end

        checks++;
        assert (neg_total > 0) else begin
            $display("no output node had a negative sum, relu clamping went unexercised");
            errors++;
        end

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0 && !hung) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/fc_pkg.sv
src/ifmap_buffer.sv
src/weight_buffer.sv
src/fc_pe_array.sv
src/fc_activation.sv
src/fc_controller.sv
src/fc_top.sv
tests/tb_fc_top.sv

// File: Bender.yml
package:
  name: fc_stage

sources:
  - files:
      - src/fc_pkg.sv
      - src/ifmap_buffer.sv
      - src/weight_buffer.sv
      - src/fc_pe_array.sv
      - src/fc_activation.sv
      - src/fc_controller.sv
      - src/fc_top.sv
  - target: simulation
    files:
      - tests/tb_fc_top.sv
